// ==== rtl/ctlb_pkg.sv ====
package ctlb_pkg;

  // organisation of the code TLB.
  localparam int num_ways = 4;
  localparam int num_sets = 64;

  // field widths of the fetch address and of an entry.
  localparam int vaddr_w    = 44;
  localparam int set_w      = 6;
  localparam int vtag_w     = 25;
  localparam int asid_w     = 24;
  localparam int ppn_w      = 29;
  localparam int csr_addr_w = 16;
  localparam int csr_data_w = 64;

  // low bit positions of the set index and the tag in a fetch address.
  localparam int set_lo = 13;
  localparam int tag_lo = 19;

  // CSRs that the TLB follows.
  localparam logic [csr_addr_w-1:0] csr_page_addr   = 16'h0c10;
  localparam logic [csr_addr_w-1:0] csr_mflags_addr = 16'h0c20;
  localparam int                    mflags_vm_bit   = 3;

  typedef logic [vaddr_w-1:0]    vaddr_t;
  typedef logic [set_w-1:0]      set_idx_t;
  typedef logic [vtag_w-1:0]     vtag_t;
  typedef logic [asid_w-1:0]     asid_t;
  typedef logic [csr_addr_w-1:0] csr_addr_t;
  typedef logic [csr_data_w-1:0] csr_data_t;

  // age 0 is the most recently used way, age 3 is the next victim.
  typedef logic [1:0] age_t;

  localparam age_t age_oldest = 2'd3;

  // translation data as delivered to fetch.
  // is_global lets an entry match under any address-space id.
  typedef struct packed {
    logic [ppn_w-1:0] ppn;
    logic             is_global;
    logic             user;
    logic             exec;
  } ctlb_data_t;

  // one stored entry of a way, 84 bits.
  typedef struct packed {
    vtag_t      vtag;
    asid_t      asid;
    logic       valid;
    age_t       age;
    ctlb_data_t data;
  } ctlb_entry_t;

endpackage

// ==== rtl/ctlb_ram.sv ====
`timescale 1ns/100ps

module ctlb_ram import ctlb_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  set_idx_t    addr,
  output ctlb_entry_t rd_entry,
  input  logic        wr_en,
  input  ctlb_entry_t wr_entry
);

  ctlb_entry_t mem [num_sets];

  // the read is combinational so that a lookup resolves in its own cycle.
  assign rd_entry = mem[addr];

  always_ff @(posedge clk)
  begin
    if (wr_en)
      mem[addr] <= wr_entry;
  end

  // an unknown index or strobe would corrupt an unknown entry.
  a_ctrl_known: assert property (
    @(posedge clk) disable iff (rst)
    !$isunknown({wr_en, addr})
  );

endmodule

// ==== rtl/ctlb_age.sv ====
`timescale 1ns/100ps

module ctlb_age import ctlb_pkg::*; (
  input  age_t old_age,
  input  age_t ref_age,
  output age_t new_age
);

  // true-LRU step for one way of the addressed set.
  // the referenced way becomes the youngest, the ways younger than it
  // move up by one and the older ways stay where they are.
  always_comb
  begin
    if (old_age == ref_age)
      new_age = '0;
    else if (old_age < ref_age)
      new_age = old_age + age_t'(1);
    else
      new_age = old_age;
  end

  // no way may age past the larger of its own and the reference age,
  // otherwise two ways of a set could end up sharing an age.
  always_comb
  begin
    if (!$isunknown({old_age, ref_age}))
    begin
      if (old_age >= ref_age)
      begin
        a_age_range_old: assert (new_age <= old_age);
      end
      else
      begin
        a_age_range_ref: assert (new_age <= ref_age);
      end
    end
  end

endmodule

// ==== rtl/csr_watch.sv ====
`timescale 1ns/100ps

module csr_watch import ctlb_pkg::*; #(
  parameter csr_addr_t watch_addr = '0
) (
  input  logic      clk,
  input  logic      rst,
  input  logic      csr_en,
  input  csr_addr_t csr_addr,
  input  csr_data_t csr_data,
  output csr_data_t value
);

  logic hit_addr;

  assign hit_addr = csr_en && (csr_addr == watch_addr);

  // shadow copy of one CSR, taken from the write bus.
  // the new value is seen by the TLB from the cycle after the write.
  always_ff @(posedge clk)
  begin
    if (rst)
      value <= '0;
    else if (hit_addr)
      value <= csr_data;
  end

endmodule

// ==== rtl/ctlb_way.sv ====
`timescale 1ns/100ps

module ctlb_way import ctlb_pkg::*; #(
  parameter int way_no = 0
) (
  input  logic       clk,
  input  logic       rst,
  input  set_idx_t   set_idx,
  input  vtag_t      vtag,
  input  asid_t      cur_asid,
  input  logic       sweep,
  input  logic       fill_en,
  input  ctlb_data_t fill_data,
  input  logic       age_upd,
  input  age_t       new_age,
  output logic       hit,
  output age_t       age,
  output ctlb_data_t data
);

  ctlb_entry_t rd_entry;
  ctlb_entry_t wr_entry;
  logic        wr_en;
  logic        tag_match;
  logic        asid_match;
  logic        victim;

  ctlb_ram ram_i (
    .clk      (clk),
    .rst      (rst),
    .addr     (set_idx),
    .rd_entry (rd_entry),
    .wr_en    (wr_en),
    .wr_entry (wr_entry)
  );

  assign tag_match = rd_entry.valid && (rd_entry.vtag == vtag);

  // a global page ignores the address-space id.
  assign asid_match = (rd_entry.asid == cur_asid) || rd_entry.data.is_global;

  assign hit  = tag_match && asid_match;
  assign age  = rd_entry.age;
  assign data = rd_entry.data;

  // the way that holds the oldest age of the set receives the fill.
  assign victim = (rd_entry.age == age_oldest);

  // every way of the set writes on a fill, the victim its new contents
  // and the others only their shifted age.
  assign wr_en = sweep || fill_en || age_upd;

  always_comb
  begin
    wr_entry     = rd_entry;
    wr_entry.age = new_age;
    if (sweep)
    begin
      // Seeding with the way number leaves a valid age permutation.
      wr_entry     = '0;
      wr_entry.age = age_t'(way_no);
    end
    else if (fill_en && victim)
    begin
      wr_entry.vtag  = vtag;
      wr_entry.asid  = cur_asid;
      wr_entry.valid = 1'b1;
      wr_entry.age   = '0;
      wr_entry.data  = fill_data;
    end
  end

endmodule

// ==== rtl/ctlb.sv ====
`timescale 1ns/100ps

module ctlb import ctlb_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       lookup_en,
  input  logic       fetch_stall,
  input  vaddr_t     lookup_addr,
  output logic       hit,
  output ctlb_data_t hit_data,
  input  logic       fill_en,
  input  ctlb_data_t fill_data,
  input  logic       csr_en,
  input  csr_addr_t  csr_addr,
  input  csr_data_t  csr_data
);

  logic                sweep;
  set_idx_t            sweep_cnt;
  set_idx_t            set_idx;
  vtag_t               vtag;
  asid_t               cur_asid;
  csr_data_t           page_val;
  csr_data_t           mflags_val;
  logic [num_ways-1:0] way_hit;
  age_t                way_age     [num_ways];
  age_t                way_new_age [num_ways];
  ctlb_data_t          way_data    [num_ways];
  age_t                hit_age;
  age_t                ref_age;
  logic                age_upd;

  // after reset every set is walked once to clear valid bits and seed ages.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      sweep     <= 1'b1;
      sweep_cnt <= '0;
    end
    else if (sweep)
    begin
      sweep_cnt <= sweep_cnt + set_idx_t'(1);
      if (sweep_cnt == set_idx_t'(num_sets - 1))
        sweep <= 1'b0;
    end
  end

  assign set_idx = sweep ? sweep_cnt : lookup_addr[set_lo +: set_w];
  assign vtag    = lookup_addr[tag_lo +: vtag_w];

  csr_watch #(.watch_addr(csr_page_addr)) page_watch_i (
    .clk      (clk),
    .rst      (rst),
    .csr_en   (csr_en),
    .csr_addr (csr_addr),
    .csr_data (csr_data),
    .value    (page_val)
  );

  csr_watch #(.watch_addr(csr_mflags_addr)) mflags_watch_i (
    .clk      (clk),
    .rst      (rst),
    .csr_en   (csr_en),
    .csr_addr (csr_addr),
    .csr_data (csr_data),
    .value    (mflags_val)
  );

  // Process number with bit 0 flipped, so that process 0 never aliases
  // the id used when translation is off.
  assign cur_asid = mflags_val[mflags_vm_bit] ? (page_val[asid_w-1:0] ^ asid_t'(1)) : '0;

  for (genvar w = 0; w < num_ways; w++)
  begin : g_way
    ctlb_way #(.way_no(w)) way_i (
      .clk       (clk),
      .rst       (rst),
      .set_idx   (set_idx),
      .vtag      (vtag),
      .cur_asid  (cur_asid),
      .sweep     (sweep),
      .fill_en   (fill_en),
      .fill_data (fill_data),
      .age_upd   (age_upd),
      .new_age   (way_new_age[w]),
      .hit       (way_hit[w]),
      .age       (way_age[w]),
      .data      (way_data[w])
    );

    ctlb_age age_i (
      .old_age (way_age[w]),
      .ref_age (ref_age),
      .new_age (way_new_age[w])
    );
  end

  assign hit = (|way_hit) && !sweep;

  always_comb
  begin
    hit_data = '0;
    hit_age  = '0;
    for (int i = 0; i < num_ways; i++)
    begin
      if (way_hit[i] && !sweep)
      begin
        hit_data = way_data[i];
        hit_age  = way_age[i];
      end
    end
  end

  // a fill replaces the oldest way, which then counts as referenced.
  assign ref_age = fill_en ? age_oldest : hit_age;
  assign age_upd = lookup_en && !fetch_stall && hit && !fill_en;

  a_one_hit: assert property (
    @(posedge clk) disable iff (rst || sweep)
    lookup_en |-> $onehot0(way_hit)
  );

  a_ages_distinct: assert property (
    @(posedge clk) disable iff (rst)
    (!sweep && (lookup_en || fill_en)) |->
      (way_age[0] != way_age[1]) && (way_age[0] != way_age[2]) &&
      (way_age[0] != way_age[3]) && (way_age[1] != way_age[2]) &&
      (way_age[1] != way_age[3]) && (way_age[2] != way_age[3])
  );

endmodule

// ==== testbench/ctlb_checker.sv ====
`timescale 1ns/100ps

module ctlb_checker import ctlb_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       lookup_en,
  input  logic       fetch_stall,
  input  vaddr_t     lookup_addr,
  input  logic       fill_en,
  input  ctlb_data_t fill_data,
  input  logic       csr_en,
  input  csr_addr_t  csr_addr,
  input  csr_data_t  csr_data,
  input  logic       hit,
  input  ctlb_data_t hit_data,
  output logic       ready,
  output int         error_count
);

  // reference copy of every set, with way w of the model standing for way w of the DUT.
  ctlb_entry_t model [num_sets][num_ways];
  csr_data_t   page_m;
  csr_data_t   mflags_m;
  set_idx_t    sweep_cnt;

  always @(posedge clk)
  begin
    set_idx_t   s;
    vtag_t      t;
    asid_t      id;
    logic       exp_hit;
    ctlb_data_t exp_data;
    age_t       h;
    if (rst)
    begin
      ready       = 1'b0;
      sweep_cnt   = '0;
      page_m      = '0;
      mflags_m    = '0;
      error_count = 0;
    end
    else
    begin
      s        = lookup_addr[18:13];
      t        = lookup_addr[43:19];
      id       = mflags_m[mflags_vm_bit] ? (page_m[23:0] ^ 24'h000001) : 24'h000000;
      exp_hit  = 1'b0;
      exp_data = '0;
      h        = '0;
      if (ready)
      begin
        for (int w = 0; w < num_ways; w++)
        begin
          if (model[s][w].valid && model[s][w].vtag == t &&
              (model[s][w].asid == id || model[s][w].data.is_global))
          begin
            exp_hit  = 1'b1;
            exp_data = model[s][w].data;
            h        = model[s][w].age;
          end
        end
      end
      if (hit !== exp_hit || hit_data !== exp_data)
      begin
        error_count++;
        $display("error at %0t ns: set %0d tag %h gave hit %b data %h, expected hit %b data %h",
                 $time, s, t, hit, hit_data, exp_hit, exp_data);
      end
      if (!ready)
      begin
        for (int w = 0; w < num_ways; w++)
        begin
          model[sweep_cnt][w]     = '0;
          model[sweep_cnt][w].age = age_t'(w);
        end
        if (sweep_cnt == set_idx_t'(num_sets - 1))
          ready = 1'b1;
        sweep_cnt = sweep_cnt + set_idx_t'(1);
      end
      else if (fill_en)
      begin
        // the way at age 3 takes the new entry and every other way grows one older.
        for (int w = 0; w < num_ways; w++)
        begin
          if (model[s][w].age == 2'd3)
            model[s][w] = '{vtag: t, asid: id, valid: 1'b1, age: 2'd0, data: fill_data};
          else
            model[s][w].age = model[s][w].age + age_t'(1);
        end
      end
      else if (lookup_en && !fetch_stall && exp_hit)
      begin
        for (int w = 0; w < num_ways; w++)
        begin
          if (model[s][w].age == h)
            model[s][w].age = 2'd0;
          else if (model[s][w].age < h)
            model[s][w].age = model[s][w].age + age_t'(1);
        end
      end
      if (csr_en && csr_addr == csr_page_addr)
        page_m = csr_data;
      if (csr_en && csr_addr == csr_mflags_addr)
        mflags_m = csr_data;
    end
  end

endmodule

// ==== testbench/ctlb_tb.sv ====
`timescale 1ns/100ps

module ctlb_tb import ctlb_pkg::*; ();

  localparam int max_wait = 200;

  logic       clk;
  logic       rst;
  logic       lookup_en;
  logic       fetch_stall;
  vaddr_t     lookup_addr;
  logic       hit;
  ctlb_data_t hit_data;
  logic       fill_en;
  ctlb_data_t fill_data;
  logic       csr_en;
  csr_addr_t  csr_addr;
  csr_data_t  csr_data;
  logic       ready;
  int         error_count;
  int         local_errors;
  int         err_mark;
  int         tests_run;
  int         tests_failed;
  int         seed;
  int         fresh;

  ctlb dut_i (.*);
  ctlb_checker check_i (.*);

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic vaddr_t addr_of(vtag_t t, set_idx_t s);
    return {t, s, 13'h0a4};
  endfunction

  function automatic ctlb_data_t data_of(vtag_t t, logic g);
    ctlb_data_t d;
    d.ppn       = {4'h0, t} ^ 29'h0a5c3e1;
    d.is_global = g;
    d.user      = t[0];
    d.exec      = !t[1];
    return d;
  endfunction

  // filled tags count up in the top of the tag space, where random lookups never go.
  function automatic vtag_t new_tag();
    fresh++;
    return {5'h1f, 20'(fresh)};
  endfunction

  task automatic idle();
    lookup_en   = 1'b0;
    fetch_stall = 1'b0;
    fill_en     = 1'b0;
    csr_en      = 1'b0;
  endtask

  task automatic fill(vtag_t t, set_idx_t s, logic g);
    @(negedge clk);
    idle();
    lookup_addr = addr_of(t, s);
    fill_en     = 1'b1;
    fill_data   = data_of(t, g);
  endtask

  task automatic probe(vtag_t t, set_idx_t s, logic stall, logic exp_hit, logic g);
    @(negedge clk);
    idle();
    lookup_addr = addr_of(t, s);
    lookup_en   = 1'b1;
    fetch_stall = stall;
    #1;
    if (hit !== exp_hit || (exp_hit && hit_data !== data_of(t, g)))
    begin
      local_errors++;
      $display("error at %0t ns: tag %h in set %0d gave hit %b data %h, expected hit %b",
               $time, t, s, hit, hit_data, exp_hit);
    end
  endtask

  task automatic write_csr(csr_addr_t a, csr_data_t d);
    @(negedge clk);
    idle();
    csr_en   = 1'b1;
    csr_addr = a;
    csr_data = d;
  endtask

  task automatic end_test(string name);
    int errs;
    @(negedge clk);
    idle();
    errs     = error_count + local_errors - err_mark;
    err_mark = error_count + local_errors;
    tests_run++;
    if (errs == 0)
      $display("test %0d %s: ok", tests_run, name);
    else
    begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, errs);
    end
  endtask

  task automatic run_tests();
    vtag_t    t [6];
    vtag_t    tq [$];
    set_idx_t sq [$];
    set_idx_t s;
    int       k;
    int       r;
    int       j;

    for (k = 0; k < 200; k++)
      probe({1'b0, 24'($random(seed))}, set_idx_t'($random(seed)), 1'b0, 1'b0, 1'b0);
    end_test("empty after sweep");

    for (k = 0; k < 12; k++)
    begin
      tq.push_back(new_tag());
      fill(tq[k], set_idx_t'(k % 4), 1'b0);
    end
    for (k = 0; k < 12; k++)
      probe(tq[k], set_idx_t'(k % 4), 1'b0, 1'b1, 1'b0);
    for (k = 0; k < 8; k++)
      probe(new_tag(), set_idx_t'(k % 4), 1'b0, 1'b0, 1'b0);
    end_test("fill and hit");

    // after four fills t0 is oldest, the two hits leave t1 as the victim.
    for (k = 0; k < 5; k++)
      t[k] = new_tag();
    for (k = 0; k < 4; k++)
      fill(t[k], 6'd40, 1'b0);
    probe(t[0], 6'd40, 1'b0, 1'b1, 1'b0);
    probe(t[2], 6'd40, 1'b0, 1'b1, 1'b0);
    fill(t[4], 6'd40, 1'b0);
    probe(t[1], 6'd40, 1'b0, 1'b0, 1'b0);
    for (k = 0; k < 5; k++)
      if (k != 1)
        probe(t[k], 6'd40, 1'b0, 1'b1, 1'b0);
    end_test("lru eviction");

    for (k = 0; k < 6; k++)
      t[k] = new_tag();
    for (k = 0; k < 4; k++)
      fill(t[k], 6'd41, 1'b0);
    probe(t[0], 6'd41, 1'b1, 1'b1, 1'b0);
    probe(t[1], 6'd41, 1'b1, 1'b1, 1'b0);
    fill(t[4], 6'd41, 1'b0);
    probe(t[0], 6'd41, 1'b0, 1'b0, 1'b0);
    probe(t[1], 6'd41, 1'b1, 1'b1, 1'b0);
    fill(t[5], 6'd41, 1'b0);
    probe(t[1], 6'd41, 1'b0, 1'b0, 1'b0);
    probe(t[2], 6'd41, 1'b0, 1'b1, 1'b0);
    end_test("stalled lookups keep ages");

    for (k = 0; k < 3; k++)
      t[k] = new_tag();
    write_csr(csr_mflags_addr, 64'h8);
    write_csr(csr_page_addr, 64'h0000_0000_0012_3456);
    fill(t[0], 6'd42, 1'b0);
    fill(t[1], 6'd42, 1'b1);
    probe(t[0], 6'd42, 1'b0, 1'b1, 1'b0);
    probe(t[1], 6'd42, 1'b0, 1'b1, 1'b1);
    write_csr(csr_page_addr, 64'h0000_0000_0abc_0000);
    probe(t[0], 6'd42, 1'b0, 1'b0, 1'b0);
    probe(t[1], 6'd42, 1'b0, 1'b1, 1'b1);
    write_csr(csr_mflags_addr, 64'h0);
    fill(t[2], 6'd42, 1'b0);
    probe(t[2], 6'd42, 1'b0, 1'b1, 1'b0);
    probe(t[0], 6'd42, 1'b0, 1'b0, 1'b0);
    // page value 1 with translation on gives id 0 again.
    write_csr(csr_page_addr, 64'h1);
    write_csr(csr_mflags_addr, 64'h8);
    probe(t[2], 6'd42, 1'b0, 1'b1, 1'b0);
    end_test("address-space ids");

    tq.delete();
    for (k = 0; k < 2000; k++)
    begin
      @(negedge clk);
      idle();
      r           = {$random(seed)} % 100;
      fetch_stall = ($random(seed) & 3) == 0;
      lookup_en   = ($random(seed) & 7) != 0;
      s           = set_idx_t'($random(seed));
      lookup_addr = addr_of({1'b0, 24'($random(seed))}, s);
      if (r < 12)
      begin
        tq.push_back(new_tag());
        sq.push_back(s);
        lookup_addr = addr_of(tq[tq.size() - 1], s);
        fill_en     = 1'b1;
        fill_data   = data_of(tq[tq.size() - 1], 1'($random(seed)));
      end
      else if (r < 16)
      begin
        csr_en   = 1'b1;
        csr_addr = (r % 3 == 0) ? csr_page_addr : (r % 3 == 1) ? csr_mflags_addr : 16'h0c30;
        csr_data = {$random(seed), $random(seed)};
      end
      else if (r < 70 && tq.size() > 0)
      begin
        j           = {$random(seed)} % tq.size();
        lookup_addr = addr_of(tq[j], sq[j]);
      end
    end
    end_test("random mix");
  endtask

  initial
  begin
    int n;
    seed         = 80;
    fresh        = 0;
    local_errors = 0;
    err_mark     = 0;
    tests_run    = 0;
    tests_failed = 0;
    rst          = 1'b1;
    idle();
    lookup_addr = '0;
    fill_data   = '0;
    csr_addr    = '0;
    csr_data    = '0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    n   = 0;
    while (!ready && n < max_wait)
    begin
      @(negedge clk);
      n++;
    end
    if (!ready)
    begin
      $display("timeout: the reset sweep did not finish within %0d cycles", max_wait);
      $display("TESTBENCH FAILED");
    end
    else
    begin
      run_tests();
      $display("%0d tests run, %0d failed, %0d model mismatches, %0d probe errors",
               tests_run, tests_failed, error_count, local_errors);
      if (tests_failed == 0 && err_mark == 0)
        $display("TESTBENCH PASSED");
      else
        $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== project.f ====
rtl/ctlb_pkg.sv
rtl/ctlb_ram.sv
rtl/ctlb_age.sv
rtl/csr_watch.sv
rtl/ctlb_way.sv
rtl/ctlb.sv
testbench/ctlb_checker.sv
testbench/ctlb_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the code TLB testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

log=sim.log

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator is not installed"
  exit 1
fi

verilator --binary --timing --assert --top-module ctlb_tb -f project.f -o ctlb_sim
status=$?
if [ $status -ne 0 ]; then
  echo "build failed with status $status"
  exit 1
fi

./obj_dir/ctlb_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TESTBENCH FAILED" "$log"; then
  echo "simulation reported a failure, see $log"
  exit 1
fi

echo "simulation finished without failures"
exit 0
